/* all.f */
hw/lsu_pkg.sv
hw/arb_pkg.sv
hw/data_mem.sv
hw/mem_port.sv
hw/mem_arbiter.sv
hw/dmem_top.sv
tb/tb_clock.sv
tb/dmem_chk.sv
tb/dmem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the data memory testbench with Verilator
log=sim.log

verilator --binary --assert --timing -j 0 --top-module dmem_tb -f all.f -o dmem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dmem_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

/* tb/dmem_tb.sv */
module dmem_tb
    import lsu_pkg::*;
    import arb_pkg::*;
;

    localparam int mem_words = 1024;
    localparam int addr_w    = 10;
    localparam int n_rnd     = 40;

    logic        clk;
    logic        reset;
    logic        psel_0;
    logic        penable_0;
    mem_op_e     op_0;
    logic [31:0] paddr_0;
    word_t       pwdata_0;
    word_t       prdata_0;
    logic        pready_0;
    logic        pslverr_0;
    logic        psel_1;
    logic        penable_1;
    mem_op_e     op_1;
    logic [31:0] paddr_1;
    word_t       pwdata_1;
    word_t       prdata_1;
    logic        pready_1;
    logic        pslverr_1;

    // stimulus table, one entry per index
    string       t_name[$];
    port_idx_t   t_port[$];
    mem_op_e     t_op[$];
    logic [31:0] t_addr[$];
    word_t       t_wdata[$];
    word_t       t_exp[$];
    logic        t_err[$];

    word_t ref_mem [mem_words];
    int    pass_count = 0;
    int    fail_count = 0;
    int    cycles = 0;
    int    limit;

    tb_clock #(.period(8)) u_clk (.clk(clk));

    dmem_top #(.mem_words(mem_words), .addr_w(addr_w)) u_dut (
        .clk(clk), .reset(reset),
        .psel_0(psel_0), .penable_0(penable_0), .op_0(op_0), .paddr_0(paddr_0),
        .pwdata_0(pwdata_0), .prdata_0(prdata_0), .pready_0(pready_0), .pslverr_0(pslverr_0),
        .psel_1(psel_1), .penable_1(penable_1), .op_1(op_1), .paddr_1(paddr_1),
        .pwdata_1(pwdata_1), .prdata_1(prdata_1), .pready_1(pready_1), .pslverr_1(pslverr_1)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("run timed out after %0d cycles, a transfer never completed", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic add_step(input string name, input port_idx_t port, input mem_op_e op,
                            input logic [31:0] addr, input word_t wd, input word_t exp,
                            input logic err);
        t_name.push_back(name);
        t_port.push_back(port);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_wdata.push_back(wd);
        t_exp.push_back(exp);
        t_err.push_back(err);
    endtask

    task automatic drive_bus(input port_idx_t port, input logic sel, input logic en,
                             input mem_op_e op, input logic [31:0] addr, input word_t wd);
        if (port) begin
            psel_1    = sel;
            penable_1 = en;
            op_1      = op;
            paddr_1   = addr;
            pwdata_1  = wd;
        end else begin
            psel_0    = sel;
            penable_0 = en;
            op_0      = op;
            paddr_0   = addr;
            pwdata_0  = wd;
        end
    endtask

    // setup, access until pready, then back to idle
    task automatic apb_xfer(input port_idx_t port, input mem_op_e op, input logic [31:0] addr,
                            input word_t wd, output word_t rd, output logic err);
        logic done;
        @(negedge clk);
        drive_bus(port, 1'b1, 1'b0, op, addr, wd);
        @(negedge clk);
        drive_bus(port, 1'b1, 1'b1, op, addr, wd);
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = port ? pready_1 : pready_0;
        end
        rd  = port ? prdata_1 : prdata_0;
        err = port ? pslverr_1 : pslverr_0;
        @(negedge clk);
        drive_bus(port, 1'b0, 1'b0, op_lw, 32'h0, 32'h0);
    endtask

    // byte lanes written from the low bytes of the store data
    task automatic model_store(input mem_op_e op, input logic [31:0] addr, input word_t wd);
        logic [addr_w-1:0] w;
        int                off;
        w   = addr[addr_w+1:2];
        off = int'(addr[1:0]);
        for (int i = 0; i < int'(op_size_bytes(op)); i++) begin
            ref_mem[w][8*(off+i) +: 8] = wd[8*i +: 8];
        end
    endtask

    function automatic word_t model_load(input mem_op_e op, input logic [31:0] addr);
        word_t w;
        word_t v;
        int    n;
        int    off;
        w   = ref_mem[addr[addr_w+1:2]];
        n   = int'(op_size_bytes(op));
        off = int'(addr[1:0]);
        v   = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = w[8*(off+i) +: 8];
        end
        // signed loads copy the top loaded bit upward
        if ((op == op_lb || op == op_lh) && v[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                v[8*i +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic check_err(input string name, input logic exp, input logic act, output bit ok);
        ok = (exp === act);
        if (!ok) begin
            $display("ERR %s: expected pslverr %0b, got %0b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act,
                              output bit ok);
        ok = (exp === act);
        if (!ok) begin
            $display("ERR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input word_t exp_d, input word_t act_d,
                               input logic exp_e, input logic act_e);
        bit ok;
        check_err(name, exp_e, act_e, ok);
        if (ok) begin
            check_word(name, exp_d, act_d, ok);
        end
        if (ok) begin
            pass_count++;
            $display("ok  %s  %h", name, act_d);
        end else begin
            fail_count++;
        end
    endtask

    // each port keeps to its own half, so cross-port order does not matter
    task automatic random_traffic(input port_idx_t port, input int base_word);
        mem_op_e     op;
        logic [1:0]  off;
        logic [31:0] addr;
        word_t       wd;
        word_t       exp;
        word_t       rd;
        logic        err;
        for (int i = 0; i < n_rnd; i++) begin
            op  = mem_op_e'(3'($urandom_range(0, 7)));
            off = 2'($urandom_range(0, 3));
            wd  = $urandom;
            if (op_size_bytes(op) == 3'd4) begin
                off = 2'b00;
            end else if (op_size_bytes(op) == 3'd2) begin
                off[0] = 1'b0;
            end
            addr = (32'(base_word + int'($urandom_range(0, 15))) << 2) | 32'(off);
            exp  = op_is_store(op) ? '0 : model_load(op, addr);
            apb_xfer(port, op, addr, wd, rd, err);
            if (op_is_store(op)) begin
                model_store(op, addr, wd);
            end
            finish_test($sformatf("rnd_p%0d_%0d", port, i), exp, rd, 1'b0, err);
        end
    endtask

    initial begin
        word_t rd;
        logic  err;
        reset = 1'b1;
        drive_bus(1'b0, 1'b0, 1'b0, op_lw, 32'h0, 32'h0);
        drive_bus(1'b1, 1'b0, 1'b0, op_lw, 32'h0, 32'h0);
        void'($urandom(32'h9e20_3071));
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = '0;
        end

        add_step("rst_lw_p0", 1'b0, op_lw, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0);
        add_step("rst_lw_p1", 1'b1, op_lw, 32'h0000_0ffc, 32'h0, 32'h0000_0000, 1'b0);
        add_step("sw_10", 1'b0, op_sw, 32'h0000_0010, 32'h1234_5678, 32'h0, 1'b0);
        add_step("lw_10", 1'b0, op_lw, 32'h0000_0010, 32'h0, 32'h1234_5678, 1'b0);
        add_step("sb_11", 1'b0, op_sb, 32'h0000_0011, 32'h0000_0080, 32'h0, 1'b0);
        add_step("lb_11", 1'b0, op_lb, 32'h0000_0011, 32'h0, 32'hffff_ff80, 1'b0);
        add_step("lbu_11", 1'b0, op_lbu, 32'h0000_0011, 32'h0, 32'h0000_0080, 1'b0);
        add_step("sb_13", 1'b0, op_sb, 32'h0000_0013, 32'h0000_00aa, 32'h0, 1'b0);
        add_step("sb_10", 1'b0, op_sb, 32'h0000_0010, 32'hffff_ff01, 32'h0, 1'b0);
        add_step("lw_10_bytes", 1'b0, op_lw, 32'h0000_0010, 32'h0, 32'haa34_8001, 1'b0);
        add_step("lb_13", 1'b0, op_lb, 32'h0000_0013, 32'h0, 32'hffff_ffaa, 1'b0);
        add_step("sb_32", 1'b0, op_sb, 32'h0000_0032, 32'h1111_11c5, 32'h0, 1'b0);
        add_step("lb_32", 1'b0, op_lb, 32'h0000_0032, 32'h0, 32'hffff_ffc5, 1'b0);
        add_step("lw_30", 1'b0, op_lw, 32'h0000_0030, 32'h0, 32'h00c5_0000, 1'b0);
        add_step("sh_22", 1'b0, op_sh, 32'h0000_0022, 32'h0000_9abc, 32'h0, 1'b0);
        add_step("sh_20", 1'b0, op_sh, 32'h0000_0020, 32'hffff_7001, 32'h0, 1'b0);
        add_step("lh_22", 1'b0, op_lh, 32'h0000_0022, 32'h0, 32'hffff_9abc, 1'b0);
        add_step("lhu_22", 1'b0, op_lhu, 32'h0000_0022, 32'h0, 32'h0000_9abc, 1'b0);
        add_step("lh_20", 1'b0, op_lh, 32'h0000_0020, 32'h0, 32'h0000_7001, 1'b0);
        add_step("lw_20", 1'b0, op_lw, 32'h0000_0020, 32'h0, 32'h9abc_7001, 1'b0);
        add_step("lh_mis", 1'b0, op_lh, 32'h0000_0021, 32'h0, 32'h0, 1'b1);
        add_step("sw_mis", 1'b0, op_sw, 32'h0000_0012, 32'hdead_beef, 32'h0, 1'b1);
        add_step("lw_10_kept", 1'b0, op_lw, 32'h0000_0010, 32'h0, 32'haa34_8001, 1'b0);
        add_step("sw_oor", 1'b0, op_sw, 32'h0000_1000, 32'hdead_beef, 32'h0, 1'b1);
        add_step("lw_0_kept", 1'b0, op_lw, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0);
        add_step("lw_oor_p1", 1'b1, op_lw, 32'hffff_fffc, 32'h0, 32'h0, 1'b1);
        add_step("sw_40_p0", 1'b0, op_sw, 32'h0000_0040, 32'hcafe_f00d, 32'h0, 1'b0);
        add_step("lw_40_p1", 1'b1, op_lw, 32'h0000_0040, 32'h0, 32'hcafe_f00d, 1'b0);
        add_step("sh_42_p1", 1'b1, op_sh, 32'h0000_0042, 32'h0000_1357, 32'h0, 1'b0);
        add_step("lw_40_p0", 1'b0, op_lw, 32'h0000_0040, 32'h0, 32'h1357_f00d, 1'b0);
        limit = 8 * (t_name.size() + 2 * n_rnd) + 100;

        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        if (pready_0 || pready_1) begin
            $display("pready is high after reset with no transfer in progress");
            fail_count++;
        end

        for (int i = 0; i < t_name.size(); i++) begin
            apb_xfer(t_port[i], t_op[i], t_addr[i], t_wdata[i], rd, err);
            if (!t_err[i] && op_is_store(t_op[i])) begin
                model_store(t_op[i], t_addr[i], t_wdata[i]);
            end
            finish_test(t_name[i], t_exp[i], rd, t_err[i], err);
        end

        fork
            random_traffic(1'b0, 0);
            random_traffic(1'b1, mem_words / 2);
        join

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb/dmem_chk.sv */
module dmem_chk
    import lsu_pkg::*;
#(
    parameter int addr_w = 10
) (
    input logic              clk,
    input logic              reset,
    input logic              psel_0,
    input logic              penable_0,
    input logic              pready_0,
    input logic              pslverr_0,
    input logic              req_0,
    input logic              we_0,
    input byte_en_t          be_0,
    input logic [addr_w-1:0] addr_0,
    input word_t             wdata_0,
    input logic              gnt_0,
    input logic              psel_1,
    input logic              penable_1,
    input logic              pready_1,
    input logic              pslverr_1,
    input logic              req_1,
    input logic              we_1,
    input byte_en_t          be_1,
    input logic [addr_w-1:0] addr_1,
    input word_t             wdata_1,
    input logic              gnt_1
);

    // a port left waiting wins the next slot
    assert property (@(posedge clk) disable iff (reset) gnt_0 && req_1 |-> ##2 gnt_1)
        else $error("port 1 not granted after waiting out a port 0 access");
    assert property (@(posedge clk) disable iff (reset) gnt_1 && req_0 |-> ##2 gnt_0)
        else $error("port 0 not granted after waiting out a port 1 access");

    // the cycle after a grant is the busy cycle
    assert property (@(posedge clk) disable iff (reset) (gnt_0 || gnt_1) |=> !(gnt_0 || gnt_1))
        else $error("grant issued while the arbiter is busy");

    assert property (@(posedge clk) disable iff (reset) pready_0 |-> psel_0 && penable_0)
        else $error("port 0 pready outside an access phase");
    assert property (@(posedge clk) disable iff (reset) pready_1 |-> psel_1 && penable_1)
        else $error("port 1 pready outside an access phase");

    // an error completion never reached the memory
    assert property (@(posedge clk) disable iff (reset) pslverr_0 |-> pready_0 && !$past(gnt_0))
        else $error("port 0 pslverr without pready or after a grant");
    assert property (@(posedge clk) disable iff (reset) pslverr_1 |-> pready_1 && !$past(gnt_1))
        else $error("port 1 pslverr without pready or after a grant");

    // a waiting request keeps its fields until granted
    assert property (@(posedge clk) disable iff (reset)
        req_0 && !gnt_0 |=> req_0 && $stable({we_0, be_0, addr_0, wdata_0}))
        else $error("port 0 request changed before grant");
    assert property (@(posedge clk) disable iff (reset)
        req_1 && !gnt_1 |=> req_1 && $stable({we_1, be_1, addr_1, wdata_1}))
        else $error("port 1 request changed before grant");

endmodule

bind dmem_top dmem_chk #(.addr_w(addr_w)) u_chk (
    .clk(clk), .reset(reset),
    .psel_0(psel_0), .penable_0(penable_0), .pready_0(pready_0), .pslverr_0(pslverr_0),
    .req_0(req_0), .we_0(we_0), .be_0(be_0), .addr_0(addr_0), .wdata_0(wdata_0),
    .gnt_0(gnt_0),
    .psel_1(psel_1), .penable_1(penable_1), .pready_1(pready_1), .pslverr_1(pslverr_1),
    .req_1(req_1), .we_1(we_1), .be_1(be_1), .addr_1(addr_1), .wdata_1(wdata_1),
    .gnt_1(gnt_1)
);

/* tb/tb_clock.sv */
module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    // free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

/* hw/dmem_top.sv */
module dmem_top
    import lsu_pkg::*;
#(
    parameter int mem_words = 1024,
    parameter int addr_w    = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel_0,
    input  logic        penable_0,
    input  mem_op_e     op_0,
    input  logic [31:0] paddr_0,
    input  word_t       pwdata_0,
    output word_t       prdata_0,
    output logic        pready_0,
    output logic        pslverr_0,
    input  logic        psel_1,
    input  logic        penable_1,
    input  mem_op_e     op_1,
    input  logic [31:0] paddr_1,
    input  word_t       pwdata_1,
    output word_t       prdata_1,
    output logic        pready_1,
    output logic        pslverr_1
);

    logic              req_0;
    logic              we_0;
    byte_en_t          be_0;
    logic [addr_w-1:0] addr_0;
    word_t             wdata_0;
    logic              gnt_0;
    logic              rvalid_0;
    logic              req_1;
    logic              we_1;
    byte_en_t          be_1;
    logic [addr_w-1:0] addr_1;
    word_t             wdata_1;
    logic              gnt_1;
    logic              rvalid_1;
    word_t             rdata;
    logic              mem_en;
    logic              mem_we;
    byte_en_t          mem_be;
    logic [addr_w-1:0] mem_addr;
    word_t             mem_wdata;
    word_t             mem_rdata;

    // core load/store side
    mem_port #(.mem_words(mem_words), .addr_w(addr_w)) u_port0 (
        .clk(clk), .reset(reset),
        .psel(psel_0), .penable(penable_0), .op(op_0), .paddr(paddr_0),
        .pwdata(pwdata_0), .prdata(prdata_0), .pready(pready_0), .pslverr(pslverr_0),
        .req(req_0), .we(we_0), .be(be_0), .word_addr(addr_0), .wdata(wdata_0),
        .gnt(gnt_0), .rvalid(rvalid_0), .rdata(rdata)
    );

    // host / debug side
    mem_port #(.mem_words(mem_words), .addr_w(addr_w)) u_port1 (
        .clk(clk), .reset(reset),
        .psel(psel_1), .penable(penable_1), .op(op_1), .paddr(paddr_1),
        .pwdata(pwdata_1), .prdata(prdata_1), .pready(pready_1), .pslverr(pslverr_1),
        .req(req_1), .we(we_1), .be(be_1), .word_addr(addr_1), .wdata(wdata_1),
        .gnt(gnt_1), .rvalid(rvalid_1), .rdata(rdata)
    );

    mem_arbiter #(.addr_w(addr_w)) u_arb (
        .clk(clk), .reset(reset),
        .req_0(req_0), .we_0(we_0), .be_0(be_0), .addr_0(addr_0), .wdata_0(wdata_0),
        .req_1(req_1), .we_1(we_1), .be_1(be_1), .addr_1(addr_1), .wdata_1(wdata_1),
        .gnt_0(gnt_0), .gnt_1(gnt_1), .rvalid_0(rvalid_0), .rvalid_1(rvalid_1),
        .rdata(rdata),
        .mem_en(mem_en), .mem_we(mem_we), .mem_be(mem_be), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    data_mem #(.mem_words(mem_words), .addr_w(addr_w)) u_mem (
        .clk(clk), .reset(reset),
        .mem_en(mem_en), .mem_we(mem_we), .mem_be(mem_be), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

/* hw/mem_arbiter.sv */
module mem_arbiter
    import lsu_pkg::*;
    import arb_pkg::*;
#(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_0,
    input  logic              we_0,
    input  byte_en_t          be_0,
    input  logic [addr_w-1:0] addr_0,
    input  word_t             wdata_0,
    input  logic              req_1,
    input  logic              we_1,
    input  byte_en_t          be_1,
    input  logic [addr_w-1:0] addr_1,
    input  word_t             wdata_1,
    output logic              gnt_0,
    output logic              gnt_1,
    output logic              rvalid_0,
    output logic              rvalid_1,
    output word_t             rdata,
    output logic              mem_en,
    output logic              mem_we,
    output byte_en_t          mem_be,
    output logic [addr_w-1:0] mem_addr,
    output word_t             mem_wdata,
    input  word_t             mem_rdata
);

    arb_state_e state;
    port_idx_t  ptr;
    port_idx_t  owner;
    port_idx_t  winner;

    // pointer breaks ties, otherwise the lone requester wins
    always_comb begin
        if (req_0 && req_1) begin
            winner = ptr;
        end else begin
            winner = req_1 ? 1'b1 : 1'b0;
        end
    end

    assign mem_en = (state == arb_idle) && (req_0 || req_1);
    assign gnt_0  = mem_en && (winner == 1'b0);
    assign gnt_1  = mem_en && (winner == 1'b1);

    assign mem_we    = winner ? we_1    : we_0;
    assign mem_be    = winner ? be_1    : be_0;
    assign mem_addr  = winner ? addr_1  : addr_0;
    assign mem_wdata = winner ? wdata_1 : wdata_0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_idle;
            ptr   <= 1'b0;
            owner <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (mem_en) begin
                        state <= arb_busy;
                        owner <= winner;
                        ptr   <= ~winner;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // read data lands during the busy cycle
    assign rvalid_0 = (state == arb_busy) && (owner == 1'b0);
    assign rvalid_1 = (state == arb_busy) && (owner == 1'b1);
    assign rdata    = mem_rdata;

endmodule

/* hw/mem_port.sv */
module mem_port
    import lsu_pkg::*;
#(
    parameter int mem_words = 1024,
    parameter int addr_w    = 10
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  mem_op_e           op,
    input  logic [31:0]       paddr,
    input  word_t             pwdata,
    output word_t             prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              req,
    output logic              we,
    output byte_en_t          be,
    output logic [addr_w-1:0] word_addr,
    output word_t             wdata,
    input  logic              gnt,
    input  logic              rvalid,
    input  word_t             rdata
);

    logic       access;
    logic [2:0] size;
    logic       misaligned;
    logic       out_of_range;
    logic       legal;
    logic       wait_q;
    logic       err_q;
    mem_op_e    op_q;
    logic [1:0] off_q;
    word_t      lane;

    assign access = psel && penable;
    assign size   = op_size_bytes(op);

    always_comb begin
        case (size)
            3'd1:    misaligned = 1'b0;
            3'd2:    misaligned = paddr[0];
            default: misaligned = |paddr[1:0];
        endcase
    end

    assign out_of_range = {2'b00, paddr[31:2]} >= 32'(mem_words);
    assign legal        = !misaligned && !out_of_range;

    // only one request outstanding, dropped once granted
    assign req       = access && legal && !wait_q;
    assign we        = op_is_store(op);
    assign word_addr = paddr[addr_w+1:2];

    // lane enables and replicated store data
    always_comb begin
        case (op)
            op_sb: begin
                be    = byte_en_t'(4'b0001 << paddr[1:0]);
                wdata = {4{pwdata[7:0]}};
            end
            op_sh: begin
                be    = paddr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{pwdata[15:0]}};
            end
            op_sw: begin
                be    = 4'b1111;
                wdata = pwdata;
            end
            default: begin
                be    = 4'b0000;
                wdata = pwdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            if (gnt) begin
                wait_q <= 1'b1;
            end else if (rvalid) begin
                wait_q <= 1'b0;
            end
            // error completes one cycle into the access phase
            err_q <= access && !legal && !err_q;
        end
    end

    // remember how to pick the load lane
    always_ff @(posedge clk) begin
        if (gnt) begin
            op_q  <= op;
            off_q <= paddr[1:0];
        end
    end

    assign lane = rdata >> {off_q, 3'b000};

    always_comb begin
        if (err_q) begin
            prdata = '0;
        end else begin
            case (op_q)
                op_lb:   prdata = {{24{lane[7]}}, lane[7:0]};
                op_lbu:  prdata = {24'b0, lane[7:0]};
                op_lh:   prdata = {{16{lane[15]}}, lane[15:0]};
                op_lhu:  prdata = {16'b0, lane[15:0]};
                op_lw:   prdata = rdata;
                default: prdata = '0;
            endcase
        end
    end

    assign pready  = rvalid || err_q;
    assign pslverr = err_q;

endmodule

/* hw/data_mem.sv */
module data_mem
    import lsu_pkg::*;
#(
    parameter int mem_words = 1024,
    parameter int addr_w    = 10
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_en,
    input  logic              mem_we,
    input  byte_en_t          mem_be,
    input  logic [addr_w-1:0] mem_addr,
    input  word_t             mem_wdata,
    output word_t             mem_rdata
);

    word_t mem [mem_words];

    // whole array clears on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_en && mem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_be[b]) begin
                    mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

    // read sees the old word on a write cycle
    always_ff @(posedge clk) begin
        if (mem_en) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

/* hw/arb_pkg.sv */
package arb_pkg;

    // busy means one memory access is in flight
    typedef enum logic {
        arb_idle = 1'b0,
        arb_busy = 1'b1
    } arb_state_e;

    // requester index for grant and round-robin pointer
    typedef logic port_idx_t;

endpackage

/* hw/lsu_pkg.sv */
package lsu_pkg;

    // integer load/store operations
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    typedef logic [31:0] word_t;

    // bit n enables byte lane n
    typedef logic [3:0] byte_en_t;

    function automatic logic op_is_store(input mem_op_e op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw);
    endfunction

    // access width in bytes
    function automatic logic [2:0] op_size_bytes(input mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 3'd1;
            op_lh, op_lhu, op_sh: return 3'd2;
            default:              return 3'd4;
        endcase
    endfunction

endpackage
